// File: Bender.yml
package:
  name: tpu_mm

sources:
  - include_dirs:
      - hw
    files:
      - hw/tpu_data_pkg.sv
      - hw/tpu_cmd_pkg.sv
      - hw/tpu_pe.sv
      - hw/tpu_systolic_array.sv
      - hw/tpu_operand_feeder.sv
      - hw/tpu_sequencer.sv
      - hw/tpu_cmd_decode.sv
      - hw/tpu_result_buffer.sv
      - hw/tpu_top.sv
  - target: test
    files:
      - tb/tpu_tb.sv

// File: hw/tpu_cmd_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "tpu_config.svh"

module tpu_cmd_decode (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     tpu_cmd_valid_i,
    input  logic [`TPU_CMD_W-1:0]    tpu_cmd_i,
    input  tpu_data_pkg::tpu_word_t  tpu_param_1_i,
    input  tpu_data_pkg::tpu_word_t  tpu_param_2_i,
    input  logic                     busy_i,
    output logic                     wr_data_o,
    output logic                     wr_weight_o,
    output tpu_cmd_pkg::tpu_idx_t    wr_lane_o,
    output tpu_cmd_pkg::tpu_offset_t wr_offset_o,
    output tpu_data_pkg::tpu_word_t  wr_value_o,
    output logic                     set_k_o,
    output logic [`TPU_K_W-1:0]      k_value_o,
    output logic                     start_o,
    output logic                     rd_req_o,
    output tpu_cmd_pkg::tpu_idx_t    rd_row_o,
    output tpu_cmd_pkg::tpu_idx_t    rd_col_o
);
    import tpu_cmd_pkg::*;

    tpu_opcode_e op;
    tpu_addr_u   addr;
    logic        accept;

    assign op   = tpu_opcode_e'(tpu_cmd_i);
    assign addr = tpu_addr_u'(tpu_param_2_i);
    // anything arriving while a run is active is lost
    assign accept = tpu_cmd_valid_i && !busy_i;

    // ##################################################
    // strobes, one cycle after acceptance
    // ##################################################
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_data_o   <= 1'b0;
            wr_weight_o <= 1'b0;
            set_k_o     <= 1'b0;
            start_o     <= 1'b0;
            rd_req_o    <= 1'b0;
        end else begin
            wr_data_o   <= accept && (op == TPU_OP_SW_WRITE_DATA);
            wr_weight_o <= accept && (op == TPU_OP_SW_WRITE_WEIGHT);
            // index 0 selects K, M and N no longer exist
            set_k_o     <= accept && (op == TPU_OP_SET_KMN) && (tpu_param_1_i == '0);
            start_o     <= accept && (op == TPU_OP_TRIGGER_CONV);
            rd_req_o    <= accept && (op == TPU_OP_SW_READ_DATA);
        end
    end

    // ##################################################
    // payload, loaded on any accepted command
    // ##################################################
    always_ff @(posedge clk_i) begin
        if (accept) begin
            // lane view for operand writes
            wr_lane_o   <= addr.lane_v.lane;
            wr_offset_o <= addr.lane_v.offset;
            wr_value_o  <= tpu_param_1_i;
            // K value rides in param 2, param 1 is the KMN index
            k_value_o   <= tpu_param_2_i[`TPU_K_W-1:0];
            // element view for result reads
            rd_row_o    <= addr.elem_v.row;
            rd_col_o    <= addr.elem_v.col;
        end
    end

endmodule

`default_nettype wire

// File: hw/tpu_cmd_pkg.sv
`default_nettype none

`include "tpu_config.svh"

package tpu_cmd_pkg;

    // lane / row / column index width
    localparam int TPU_IDX_W = $clog2(`TPU_ARRAY_DIM);
    // unused upper bits of each address view
    localparam int TPU_LANE_PAD_W = `TPU_DATA_W - TPU_IDX_W - `TPU_BUF_ADDR_W;
    localparam int TPU_ELEM_PAD_W = `TPU_DATA_W - 2 * TPU_IDX_W;

    typedef logic [TPU_IDX_W-1:0]       tpu_idx_t;
    typedef logic [`TPU_BUF_ADDR_W-1:0] tpu_offset_t;

    // kept command codes, numbering as on the original command port
    typedef enum logic [`TPU_CMD_W-1:0] {
        TPU_OP_TRIGGER_CONV    = 8'd1,
        TPU_OP_SW_WRITE_DATA   = 8'd9,
        TPU_OP_SW_WRITE_WEIGHT = 8'd10,
        TPU_OP_SET_KMN         = 8'd13,
        TPU_OP_SW_READ_DATA    = 8'd14
    } tpu_opcode_e;

    // buffer writes: lane select plus word offset
    typedef struct packed {
        logic [TPU_LANE_PAD_W-1:0] pad;
        tpu_idx_t                  lane;
        tpu_offset_t               offset;
    } tpu_lane_view_t;

    // result reads: one element of the output tile
    typedef struct packed {
        logic [TPU_ELEM_PAD_W-1:0] pad;
        tpu_idx_t                  row;
        tpu_idx_t                  col;
    } tpu_elem_view_t;

    // param 2 word, decoded by opcode
    typedef union packed {
        tpu_lane_view_t lane_v;
        tpu_elem_view_t elem_v;
    } tpu_addr_u;

endpackage

`default_nettype wire

// File: hw/tpu_config.svh
`ifndef TPU_CONFIG_SVH
`define TPU_CONFIG_SVH

// ##################################################
// array geometry
// ##################################################

// side of the square PE grid, also lane count per buffer
`define TPU_ARRAY_DIM 4

// ##################################################
// widths
// ##################################################

// operands, params and results share one word width
`define TPU_DATA_W 32
// per-lane buffer address, 256 words deep
`define TPU_BUF_ADDR_W 8
// opcode field of the command port
`define TPU_CMD_W 8
// shared dimension K, one bit wider than the buffer address
`define TPU_K_W 9

`endif

// File: hw/tpu_data_pkg.sv
`default_nettype none

`include "tpu_config.svh"

package tpu_data_pkg;

    // one operand, weight or accumulator word
    typedef logic [`TPU_DATA_W-1:0] tpu_word_t;

    // one word per lane, lane 0 in the low word
    typedef tpu_word_t [`TPU_ARRAY_DIM-1:0] tpu_lane_vec_t;

    // full output tile, row-major
    // element (row, col) sits at row * DIM + col
    typedef tpu_word_t [`TPU_ARRAY_DIM*`TPU_ARRAY_DIM-1:0] tpu_acc_grid_t;

endpackage

`default_nettype wire

// File: hw/tpu_operand_feeder.sv
`timescale 1ns/1ps
`default_nettype none

`include "tpu_config.svh"

module tpu_operand_feeder (
    input  logic                        clk_i,
    input  logic                        wr_data_i,
    input  logic                        wr_weight_i,
    input  tpu_cmd_pkg::tpu_idx_t       wr_lane_i,
    input  tpu_cmd_pkg::tpu_offset_t    wr_offset_i,
    input  tpu_data_pkg::tpu_word_t     wr_value_i,
    input  logic [`TPU_K_W-1:0]         step_i,
    input  logic                        feed_en_i,
    input  logic [`TPU_K_W-1:0]         k_len_i,
    output tpu_data_pkg::tpu_lane_vec_t data_vec_o,
    output tpu_data_pkg::tpu_lane_vec_t weight_vec_o
);
    import tpu_cmd_pkg::*;
    import tpu_data_pkg::*;

    localparam int DEPTH = 2 ** `TPU_BUF_ADDR_W;
    // buffer kinds: 0 data (rows of A), 1 weight (columns of B)
    localparam int KINDS = 2;

    tpu_word_t           mem_q [KINDS][`TPU_ARRAY_DIM][DEPTH];
    tpu_lane_vec_t       vec_q [KINDS];
    logic [KINDS-1:0]    wr_en;
    logic [`TPU_K_W-1:0] off [`TPU_ARRAY_DIM];
    logic [`TPU_ARRAY_DIM-1:0] hit;

    assign wr_en = {wr_weight_i, wr_data_i};

    // ##################################################
    // skewed read offsets
    // ##################################################
    always_comb begin
        for (int l = 0; l < `TPU_ARRAY_DIM; l++) begin
            // lane l lags by l steps
            // below zero wraps high, so one compare covers both ends
            off[l] = step_i - `TPU_K_W'(l);
            hit[l] = feed_en_i && (off[l] < k_len_i);
        end
    end

    // ##################################################
    // lane memories, registered reads
    // ##################################################
    always_ff @(posedge clk_i) begin
        for (int k = 0; k < KINDS; k++) begin
            for (int l = 0; l < `TPU_ARRAY_DIM; l++) begin
                if (wr_en[k] && (wr_lane_i == tpu_idx_t'(l))) begin
                    mem_q[k][l][wr_offset_i] <= wr_value_i;
                end
                // zero padding outside 0..K-1 and between runs
                if (hit[l]) begin
                    vec_q[k][l] <= mem_q[k][l][off[l][`TPU_BUF_ADDR_W-1:0]];
                end else begin
                    vec_q[k][l] <= '0;
                end
            end
        end
    end

    assign data_vec_o   = vec_q[0];
    assign weight_vec_o = vec_q[1];

endmodule

`default_nettype wire

// File: hw/tpu_pe.sv
`timescale 1ns/1ps
`default_nettype none

module tpu_pe (
    input  logic                    clk_i,
    input  logic                    clear_i,
    input  tpu_data_pkg::tpu_word_t a_i,
    input  tpu_data_pkg::tpu_word_t b_i,
    output tpu_data_pkg::tpu_word_t a_o,
    output tpu_data_pkg::tpu_word_t b_o,
    output tpu_data_pkg::tpu_word_t acc_o
);

    // operands move one cell per cycle
    // a to the right, b downward
    always_ff @(posedge clk_i) begin
        a_o <= a_i;
        b_o <= b_i;
    end

    // output-stationary accumulate
    // product and sum both truncated to the word width
    always_ff @(posedge clk_i) begin
        if (clear_i) begin
            acc_o <= '0;
        end else begin
            acc_o <= acc_o + a_i * b_i;
        end
    end

endmodule

`default_nettype wire

// File: hw/tpu_result_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module tpu_result_buffer (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        store_i,
    input  tpu_data_pkg::tpu_acc_grid_t acc_grid_i,
    input  logic                        rd_req_i,
    input  tpu_cmd_pkg::tpu_idx_t       rd_row_i,
    input  tpu_cmd_pkg::tpu_idx_t       rd_col_i,
    output logic                        ret_valid_o,
    output tpu_data_pkg::tpu_word_t     ret_data_o
);
    import tpu_data_pkg::*;

    tpu_acc_grid_t grid_q;
    tpu_word_t     word_q;
    logic          req_q;

    // results read back as zero until the first run completes
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            grid_q <= '0;
        end else if (store_i) begin
            grid_q <= acc_grid_i;
        end
    end

    // ##################################################
    // readback, two stages after the decoded request
    // ##################################################

    // stage 1: pick one element, row-major index
    always_ff @(posedge clk_i) begin
        word_q <= grid_q[{rd_row_i, rd_col_i}];
    end

    // stage 2: single-cycle return, data zero otherwise
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            req_q       <= 1'b0;
            ret_valid_o <= 1'b0;
            ret_data_o  <= '0;
        end else begin
            req_q       <= rd_req_i;
            ret_valid_o <= req_q;
            ret_data_o  <= req_q ? word_q : '0;
        end
    end

endmodule

`default_nettype wire

// File: hw/tpu_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "tpu_config.svh"

module tpu_sequencer (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                set_k_i,
    input  logic [`TPU_K_W-1:0] k_value_i,
    input  logic                start_i,
    output logic [`TPU_K_W-1:0] k_len_o,
    output logic [`TPU_K_W-1:0] step_o,
    output logic                feed_en_o,
    output logic                clear_o,
    output logic                store_o,
    output logic                busy_o
);

    // extra steps so the skewed wavefront reaches the far corner
    localparam int SKEW = 2 * (`TPU_ARRAY_DIM - 1);

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_FEED,
        SEQ_DRAIN
    } seq_state_e;

    seq_state_e          state_q;
    logic [`TPU_K_W-1:0] k_q;
    logic [`TPU_K_W-1:0] step_q;
    logic                drain_q;
    logic                feed_last;

    // K + SKEW steps in total, K at most 256
    assign feed_last = (step_q == k_q + `TPU_K_W'(SKEW - 1));

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= SEQ_IDLE;
            k_q     <= `TPU_K_W'(1);
            step_q  <= '0;
            drain_q <= 1'b0;
        end else begin
            // decoder only lets this through while idle
            if (set_k_i) begin
                k_q <= k_value_i;
            end
            case (state_q)
                SEQ_IDLE: begin
                    if (start_i) begin
                        state_q <= SEQ_FEED;
                        step_q  <= '0;
                    end
                end
                SEQ_FEED: begin
                    if (feed_last) begin
                        state_q <= SEQ_DRAIN;
                        drain_q <= 1'b0;
                    end else begin
                        step_q <= step_q + 1'b1;
                    end
                end
                SEQ_DRAIN: begin
                    // first cycle: last buffer read lands, second: last MAC
                    if (drain_q) begin
                        state_q <= SEQ_IDLE;
                    end
                    drain_q <= 1'b1;
                end
                default: state_q <= SEQ_IDLE;
            endcase
        end
    end

    assign k_len_o   = k_q;
    assign step_o    = step_q;
    assign feed_en_o = (state_q == SEQ_FEED);
    // zero the accumulators the cycle before step 0
    assign clear_o   = start_i && (state_q == SEQ_IDLE);
    // grid is final during the last drain cycle
    assign store_o   = (state_q == SEQ_DRAIN) && drain_q;
    // high from the start pulse, low the cycle after store
    assign busy_o    = start_i || (state_q != SEQ_IDLE);

endmodule

`default_nettype wire

// File: hw/tpu_systolic_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "tpu_config.svh"

module tpu_systolic_array (
    input  logic                        clk_i,
    input  logic                        clear_i,
    input  tpu_data_pkg::tpu_lane_vec_t data_vec_i,
    input  tpu_data_pkg::tpu_lane_vec_t weight_vec_i,
    output tpu_data_pkg::tpu_acc_grid_t acc_grid_o
);
    import tpu_data_pkg::*;

    localparam int DIM = `TPU_ARRAY_DIM;

    // horizontal links per row, one more than cells
    tpu_word_t a_link [DIM][DIM+1];
    // vertical links per column
    tpu_word_t b_link [DIM+1][DIM];

    for (genvar r = 0; r < DIM; r++) begin : g_row
        // data lane r enters row r at the left edge
        assign a_link[r][0] = data_vec_i[r];
        for (genvar c = 0; c < DIM; c++) begin : g_col
            // weight lane c enters column c at the top
            if (r == 0) begin : g_top
                assign b_link[0][c] = weight_vec_i[c];
            end

            tpu_pe u_pe (
                .clk_i   (clk_i),
                .clear_i (clear_i),
                .a_i     (a_link[r][c]),
                .b_i     (b_link[r][c]),
                .a_o     (a_link[r][c+1]),
                .b_o     (b_link[r+1][c]),
                .acc_o   (acc_grid_o[r*DIM+c])
            );
        end
    end

endmodule

`default_nettype wire

// File: hw/tpu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "tpu_config.svh"

module tpu_top (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    tpu_cmd_valid_i,
    input  logic [`TPU_CMD_W-1:0]   tpu_cmd_i,
    input  tpu_data_pkg::tpu_word_t tpu_param_1_i,
    input  tpu_data_pkg::tpu_word_t tpu_param_2_i,
    output logic                    ret_valid_o,
    output tpu_data_pkg::tpu_word_t ret_data_o,
    output logic                    tpu_busy_o
);
    import tpu_cmd_pkg::*;
    import tpu_data_pkg::*;

    // decode to feeder / sequencer / result buffer
    logic                wr_data;
    logic                wr_weight;
    tpu_idx_t            wr_lane;
    tpu_offset_t         wr_offset;
    tpu_word_t           wr_value;
    logic                set_k;
    logic [`TPU_K_W-1:0] k_value;
    logic                start;
    logic                rd_req;
    tpu_idx_t            rd_row;
    tpu_idx_t            rd_col;

    // sequencer outputs
    logic [`TPU_K_W-1:0] k_len;
    logic [`TPU_K_W-1:0] step;
    logic                feed_en;
    logic                clear;
    logic                store;

    // datapath
    tpu_lane_vec_t       data_vec;
    tpu_lane_vec_t       weight_vec;
    tpu_acc_grid_t       acc_grid;

    // ##################################################
    // input side
    // ##################################################
    tpu_cmd_decode u_decode (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .tpu_cmd_valid_i (tpu_cmd_valid_i),
        .tpu_cmd_i       (tpu_cmd_i),
        .tpu_param_1_i   (tpu_param_1_i),
        .tpu_param_2_i   (tpu_param_2_i),
        .busy_i          (tpu_busy_o),
        .wr_data_o       (wr_data),
        .wr_weight_o     (wr_weight),
        .wr_lane_o       (wr_lane),
        .wr_offset_o     (wr_offset),
        .wr_value_o      (wr_value),
        .set_k_o         (set_k),
        .k_value_o       (k_value),
        .start_o         (start),
        .rd_req_o        (rd_req),
        .rd_row_o        (rd_row),
        .rd_col_o        (rd_col)
    );

    // ##################################################
    // processing
    // ##################################################
    tpu_sequencer u_seq (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .set_k_i   (set_k),
        .k_value_i (k_value),
        .start_i   (start),
        .k_len_o   (k_len),
        .step_o    (step),
        .feed_en_o (feed_en),
        .clear_o   (clear),
        .store_o   (store),
        .busy_o    (tpu_busy_o)
    );

    tpu_operand_feeder u_feeder (
        .clk_i        (clk_i),
        .wr_data_i    (wr_data),
        .wr_weight_i  (wr_weight),
        .wr_lane_i    (wr_lane),
        .wr_offset_i  (wr_offset),
        .wr_value_i   (wr_value),
        .step_i       (step),
        .feed_en_i    (feed_en),
        .k_len_i      (k_len),
        .data_vec_o   (data_vec),
        .weight_vec_o (weight_vec)
    );

    tpu_systolic_array u_array (
        .clk_i        (clk_i),
        .clear_i      (clear),
        .data_vec_i   (data_vec),
        .weight_vec_i (weight_vec),
        .acc_grid_o   (acc_grid)
    );

    // ##################################################
    // output side
    // ##################################################
    tpu_result_buffer u_result (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .store_i     (store),
        .acc_grid_i  (acc_grid),
        .rd_req_i    (rd_req),
        .rd_row_i    (rd_row),
        .rd_col_i    (rd_col),
        .ret_valid_o (ret_valid_o),
        .ret_data_o  (ret_data_o)
    );

endmodule

`default_nettype wire

// File: sources.f
+incdir+hw
hw/tpu_data_pkg.sv
hw/tpu_cmd_pkg.sv
hw/tpu_pe.sv
hw/tpu_systolic_array.sv
hw/tpu_operand_feeder.sv
hw/tpu_sequencer.sv
hw/tpu_cmd_decode.sv
hw/tpu_result_buffer.sv
hw/tpu_top.sv
tb/tpu_tb.sv

// File: tb/tpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tpu_tb;

    localparam int CLK_PERIOD = 100;
    localparam int DRV_DLY    = 10;
    localparam int DIM        = 4;
    localparam int DEPTH      = 256;

    // command codes on the port
    localparam logic [7:0] OP_TRIGGER   = 8'd1;
    localparam logic [7:0] OP_WR_DATA   = 8'd9;
    localparam logic [7:0] OP_WR_WEIGHT = 8'd10;
    localparam logic [7:0] OP_SET_KMN   = 8'd13;
    localparam logic [7:0] OP_RD_DATA   = 8'd14;

    // ##################################################
    // cycle budget
    // ##################################################
    // operand loads for K = 1, 4 and 16
    localparam int LOAD_CYCLES = 2 * DIM * (1 + 4 + 16);
    // seven full readbacks, 4 cycles per read at most
    localparam int READ_CYCLES = 7 * DIM * DIM * 4;
    // K + 20 per run, runs with K = 1, 4, 16, 16, 3
    localparam int RUN_CYCLES  = (1 + 20) + (4 + 20) + 2 * (16 + 20) + (3 + 20);
    // reset, K setup, dropped and ignored commands
    localparam int MISC_CYCLES = 64;
    localparam int CYCLE_LIMIT = 2 * (LOAD_CYCLES + READ_CYCLES + RUN_CYCLES + MISC_CYCLES);

    logic        clk_i;
    logic        rst_i;
    logic        tpu_cmd_valid_i;
    logic [7:0]  tpu_cmd_i;
    logic [31:0] tpu_param_1_i;
    logic [31:0] tpu_param_2_i;
    logic        ret_valid_o;
    logic [31:0] ret_data_o;
    logic        tpu_busy_o;

    // reference operands, a_m[i][k] = A[i][k], b_m[j][k] = B[k][j]
    logic [31:0] a_m [DIM][DEPTH];
    logic [31:0] b_m [DIM][DEPTH];
    int          k_m;
    int          value_errs;
    int          other_errs;
    int          cycle_cnt = 0;
    logic        in_run;
    logic [2:0]  ret_exp_q;
    logic        rd_accept;

    tpu_top dut_i (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .tpu_cmd_valid_i (tpu_cmd_valid_i),
        .tpu_cmd_i       (tpu_cmd_i),
        .tpu_param_1_i   (tpu_param_1_i),
        .tpu_param_2_i   (tpu_param_2_i),
        .ret_valid_o     (ret_valid_o),
        .ret_data_o      (ret_data_o),
        .tpu_busy_o      (tpu_busy_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ##################################################
    // return strobe prediction and protocol checks
    // ##################################################
    // a read counts only when sent outside a run
    assign rd_accept = tpu_cmd_valid_i && (tpu_cmd_i == OP_RD_DATA) && !in_run;

    // strobe due two edges after the accepting edge
    always @(posedge clk_i) begin
        if (rst_i) begin
            ret_exp_q <= '0;
        end else begin
            ret_exp_q <= {ret_exp_q[1:0], rd_accept};
        end
    end

    assert property (@(negedge clk_i) disable iff (rst_i) ret_valid_o == ret_exp_q[2])
        else begin
            value_errs++;
            $display("ERR @%0t: ret_valid_o is %0b, expected %0b", $time, ret_valid_o,
                     ret_exp_q[2]);
        end

    assert property (@(negedge clk_i) disable iff (rst_i) !ret_valid_o |-> ret_data_o == '0)
        else begin
            value_errs++;
            $display("ERR @%0t: ret_data_o is %08h without a return strobe", $time,
                     ret_data_o);
        end

    // nothing comes back while a product is running
    assert property (@(negedge clk_i) disable iff (rst_i) !(in_run && ret_valid_o))
        else begin
            other_errs++;
            $display("a return strobe appeared during a run at %0t", $time);
        end

    // watchdog
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: test still running after %0d cycles", CYCLE_LIMIT);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // ##################################################
    // command tasks, entered and left DRV_DLY after an edge
    // ##################################################
    task automatic send_cmd(input logic [7:0] op, input logic [31:0] p1,
                            input logic [31:0] p2);
        tpu_cmd_valid_i = 1'b1;
        tpu_cmd_i       = op;
        tpu_param_1_i   = p1;
        tpu_param_2_i   = p2;
        @(posedge clk_i);
        #DRV_DLY;
        tpu_cmd_valid_i = 1'b0;
        tpu_cmd_i       = '0;
    endtask

    // command meant for the busy window
    task automatic send_while_busy(input logic [7:0] op, input logic [31:0] p1,
                                   input logic [31:0] p2);
        assert (tpu_busy_o) else begin
            other_errs++;
            $display("busy fell before a command meant for the busy window was sent");
        end
        send_cmd(op, p1, p2);
    endtask

    // index 0 of SET_KMN is K, value in param 2
    task automatic set_k(input int k_len);
        send_cmd(OP_SET_KMN, 32'd0, 32'(k_len));
        k_m = k_len;
    endtask

    // random A and B over offsets 0..K-1, lane in bits 9:8, offset in 7:0
    task automatic load_operands(input int k_len, input logic [31:0] mask,
                                 input logic [31:0] force_bits);
        for (int l = 0; l < DIM; l++) begin
            for (int k = 0; k < k_len; k++) begin
                a_m[l][k] = ($urandom() & mask) | force_bits;
                b_m[l][k] = ($urandom() & mask) | force_bits;
                send_cmd(OP_WR_DATA, a_m[l][k], 32'(l * DEPTH + k));
                send_cmd(OP_WR_WEIGHT, b_m[l][k], 32'(l * DEPTH + k));
            end
        end
    endtask

    task automatic start_run();
        send_cmd(OP_TRIGGER, 32'd0, 32'd0);
        in_run = 1'b1;
        assert (tpu_busy_o) else begin
            other_errs++;
            $display("busy did not rise after the trigger");
        end
    endtask

    task automatic wait_run(input int k_len);
        int waited;
        waited = 0;
        while (tpu_busy_o && waited < k_len + 20) begin
            @(posedge clk_i);
            #DRV_DLY;
            waited++;
        end
        assert (!tpu_busy_o) else begin
            other_errs++;
            $display("run with K=%0d did not end within %0d cycles", k_len, k_len + 20);
        end
        in_run = 1'b0;
    endtask

    // C[i][j] = sum over k of A[i][k] * B[k][j], mod 2^32
    function automatic logic [31:0] model_elem(input int i, input int j);
        logic [31:0] sum;
        sum = '0;
        for (int k = 0; k < k_m; k++) begin
            sum = sum + a_m[i][k] * b_m[j][k];
        end
        return sum;
    endfunction

    // row in bits 3:2, column in bits 1:0
    task automatic read_expect(input int row, input int col, input logic [31:0] exp_val);
        int waited;
        waited = 0;
        send_cmd(OP_RD_DATA, 32'd0, 32'(row * DIM + col));
        while (!ret_valid_o && waited < 4) begin
            @(posedge clk_i);
            #DRV_DLY;
            waited++;
        end
        if (!ret_valid_o) begin
            other_errs++;
            $display("read of element (%0d,%0d) got no return strobe", row, col);
        end else begin
            assert (ret_data_o == exp_val) else begin
                value_errs++;
                $display("ERR @%0t: C[%0d][%0d] is %08h, expected %08h", $time, row, col,
                         ret_data_o, exp_val);
            end
        end
    endtask

    task automatic read_all(input logic expect_zero);
        for (int i = 0; i < DIM; i++) begin
            for (int j = 0; j < DIM; j++) begin
                read_expect(i, j, expect_zero ? 32'd0 : model_elem(i, j));
            end
        end
    endtask

    // ##################################################
    // test sequence
    // ##################################################
    initial begin
        void'($urandom(64));
        rst_i           = 1'b1;
        tpu_cmd_valid_i = 1'b0;
        tpu_cmd_i       = '0;
        tpu_param_1_i   = '0;
        tpu_param_2_i   = '0;
        in_run          = 1'b0;
        value_errs      = 0;
        other_errs      = 0;
        k_m             = 1;
        repeat (4) @(posedge clk_i);
        #DRV_DLY;
        rst_i = 1'b0;

        // idle after reset, results zero
        assert (!tpu_busy_o && !ret_valid_o) else begin
            other_errs++;
            $display("busy or return strobe high right after reset");
        end
        read_all(1'b1);

        // small products, no wrap for K = 1
        set_k(1);
        load_operands(1, 32'h0000_0fff, 32'd0);
        start_run();
        wait_run(1);
        read_all(1'b0);
        set_k(4);
        load_operands(4, 32'hffff_ffff, 32'd0);
        start_run();
        wait_run(4);
        read_all(1'b0);

        // large operands, every product wraps
        set_k(16);
        load_operands(16, 32'hffff_ffff, 32'h8000_0001);
        start_run();
        wait_run(16);
        read_all(1'b0);
        // results stay put
        read_all(1'b0);

        // same operands again, everything sent during the run is lost
        start_run();
        for (int l = 0; l < DIM; l++) begin
            send_while_busy(OP_WR_DATA, 32'hdead_beef, 32'(l * DEPTH + l));
            send_while_busy(OP_WR_WEIGHT, 32'hcafe_f00d, 32'(l * DEPTH + l));
        end
        send_while_busy(OP_RD_DATA, 32'd0, 32'd5);
        send_while_busy(OP_SET_KMN, 32'd0, 32'd2);
        send_while_busy(OP_RD_DATA, 32'd0, 32'd10);
        wait_run(16);
        read_all(1'b0);

        // unknown codes and K indices 1, 2 leave K at 3
        set_k(3);
        send_cmd(8'd11, 32'h1234_5678, 32'd0);
        send_cmd(8'd0, 32'h1111_1111, 32'h0000_0101);
        send_cmd(8'd2, 32'd0, 32'd7);
        send_cmd(8'hff, 32'h0, 32'h0000_0302);
        send_cmd(OP_SET_KMN, 32'd1, 32'd7);
        send_cmd(OP_SET_KMN, 32'd2, 32'd9);
        start_run();
        wait_run(3);
        read_all(1'b0);

        $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
